// ==== common/la_cfg.svh ====
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

// Number of capture channels
`define LA_CHANNELS 9

// Bits captured per channel, any multiple of 8
`define LA_DEPTH 64
`define LA_DEPTH_BYTES (`LA_DEPTH / 8)

// Downsample register width
`define LA_DS_WIDTH 16

// Width of the bus byte counter
`define LA_BYTECNT_WIDTH 7

// Returned for a read select past the last channel
`define LA_BAD_SELECT_BYTE 8'hA5

`endif

// ==== common/la_pkg.sv ====
`default_nettype none

package la_pkg;

   // Byte-wide register map
   typedef enum logic [7:0] {
      READ_SELECT    = 8'd0,  // Write picks a channel, read returns a data byte
      CAPTURE_GROUP  = 8'd1,
      STATUS         = 8'd2,  // Bit 0 is capturing
      TRIGGER_SOURCE = 8'd3,
      MANUAL_CAPTURE = 8'd4,
      DOWNSAMPLE     = 8'd5,  // Two bytes
      CAPTURE_DEPTH  = 8'd6   // Two bytes, read only
   } la_reg_addr_e;

   // Trigger sources, anything else means no trigger
   typedef enum logic [2:0] {
      TRIG_GLITCH_GO      = 3'd0,
      TRIG_CAPTURE_ACTIVE = 3'd1,
      TRIG_HS1            = 3'd2,
      TRIG_DEBUG          = 3'd3
   } la_trig_src_e;

   // Probe groups
   // Unlisted codes select the 1,0,1,0 test pattern
   typedef enum logic [2:0] {
      GRP_IO     = 3'd0,
      GRP_USERIO = 3'd1,
      GRP_DEBUG  = 3'd2,
      GRP_TRACE  = 3'd3
   } la_group_e;

endpackage

`default_nettype wire

// ==== common/la_ctrl_if.sv ====
`default_nettype none
`include "la_cfg.svh"

interface la_ctrl_if;

   // Configuration, owned by the register block
   la_pkg::la_trig_src_e     trigger_source;
   la_pkg::la_group_e        capture_group;
   logic [3:0]               read_select;
   logic [`LA_DS_WIDTH-1:0]  downsample;
   logic                     manual_capture;

   // Status and readback from the capture engine
   logic                     capturing;
   logic [`LA_DEPTH-1:0]     channel_data;  // Selected channel, registered

   modport regs (
      output trigger_source,
      output capture_group,
      output read_select,
      output downsample,
      output manual_capture,
      input  capturing,
      input  channel_data
   );

   modport trigger (
      input  trigger_source,
      input  manual_capture
   );

   modport timer (
      input  downsample
   );

   modport capture (
      input  capture_group,
      input  read_select,
      output capturing,
      output channel_data
   );

endinterface

`default_nettype wire

// ==== source/la_regs.sv ====
`default_nettype none
`include "la_cfg.svh"

module la_regs (
   input  wire                          observer_clk,
   input  wire                          reset,
   input  wire [7:0]                    reg_address,
   input  wire [`LA_BYTECNT_WIDTH-1:0]  reg_bytecnt,
   input  wire [7:0]                    reg_datai,
   input  wire                          reg_read,
   input  wire                          reg_write,
   output logic [7:0]                   reg_datao,
   la_ctrl_if.regs                      ctrl
);

   localparam int DS_BYTES = `LA_DS_WIDTH / 8;

   localparam logic [`LA_BYTECNT_WIDTH-1:0] DATA_BYTES =
      `LA_BYTECNT_WIDTH'(`LA_DEPTH_BYTES);
   localparam logic [`LA_BYTECNT_WIDTH-1:0] DS_LAST =
      `LA_BYTECNT_WIDTH'(DS_BYTES);

   // Capture depth as seen by software, two bytes
   localparam logic [15:0] DEPTH_VALUE = 16'(`LA_DEPTH);

   la_pkg::la_reg_addr_e addr;

   assign addr = la_pkg::la_reg_addr_e'(reg_address);

   // Write decode, new values seen on the next clock
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ctrl.trigger_source <= la_pkg::TRIG_GLITCH_GO;
         ctrl.capture_group  <= la_pkg::GRP_IO;
         ctrl.read_select    <= '0;
         ctrl.downsample     <= '0;
         ctrl.manual_capture <= 1'b0;
      end else if (reg_write) begin
         case (addr)
            la_pkg::READ_SELECT:    ctrl.read_select <= reg_datai[3:0];
            la_pkg::CAPTURE_GROUP:
               ctrl.capture_group <= la_pkg::la_group_e'(reg_datai[2:0]);
            la_pkg::TRIGGER_SOURCE:
               ctrl.trigger_source <= la_pkg::la_trig_src_e'(reg_datai[2:0]);
            la_pkg::MANUAL_CAPTURE: ctrl.manual_capture <= reg_datai[0];
            la_pkg::DOWNSAMPLE: begin
               if (reg_bytecnt < DS_LAST) begin
                  ctrl.downsample[reg_bytecnt*8 +: 8] <= reg_datai;
               end
            end
            default: ;  // STATUS and CAPTURE_DEPTH are read only
         endcase
      end
   end

   // Read mux, combinational and zero outside a read
   always_comb begin
      reg_datao = 8'h00;
      if (reg_read) begin
         case (addr)
            la_pkg::READ_SELECT: begin
               if (reg_bytecnt < DATA_BYTES) begin
                  reg_datao = ctrl.channel_data[reg_bytecnt*8 +: 8];
               end
            end
            la_pkg::CAPTURE_GROUP:  reg_datao = {5'b0, ctrl.capture_group};
            la_pkg::STATUS:         reg_datao = {7'b0, ctrl.capturing};
            la_pkg::TRIGGER_SOURCE: reg_datao = {5'b0, ctrl.trigger_source};
            la_pkg::MANUAL_CAPTURE: reg_datao = {7'b0, ctrl.manual_capture};
            la_pkg::DOWNSAMPLE: begin
               if (reg_bytecnt < DS_LAST) begin
                  reg_datao = ctrl.downsample[reg_bytecnt*8 +: 8];
               end
            end
            la_pkg::CAPTURE_DEPTH: begin
               if (reg_bytecnt < 2) begin
                  reg_datao = DEPTH_VALUE[reg_bytecnt*8 +: 8];
               end
            end
            default: reg_datao = 8'h00;  // Unknown address
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== trigger/la_trigger.sv ====
`default_nettype none

module la_trigger (
   input  wire        observer_clk,
   input  wire        reset,
   input  wire        glitch_go,
   input  wire        capture_active,
   input  wire        hs1,
   input  wire        debug0,
   la_ctrl_if.trigger ctrl,
   output logic       capture_go
);

   logic       trig_level;  // Asynchronous, straight from the pins
   logic [1:0] sync_q;
   logic [1:0] edge_q;

   // Source select, manual capture always wins
   always_comb begin
      case (ctrl.trigger_source)
         la_pkg::TRIG_GLITCH_GO:      trig_level = glitch_go;
         la_pkg::TRIG_CAPTURE_ACTIVE: trig_level = capture_active;
         la_pkg::TRIG_HS1:            trig_level = hs1;
         la_pkg::TRIG_DEBUG:          trig_level = debug0;
         default:                     trig_level = 1'b0;
      endcase
      trig_level = trig_level | ctrl.manual_capture;
   end

   // Two sync flops, then the edge stage
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_q <= 2'b00;
         edge_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], trig_level};
         edge_q <= {edge_q[0], sync_q[1]};
      end
   end

   // One cycle per rising edge
   assign capture_go = edge_q[0] & ~edge_q[1];

endmodule

`default_nettype wire

// ==== source/la_sample_timer.sv ====
`default_nettype none
`include "la_cfg.svh"

module la_sample_timer (
   input  wire       observer_clk,
   input  wire       reset,
   input  wire       capture_go,
   la_ctrl_if.timer  ctrl,
   output logic      sample_strobe
);

   logic [`LA_DS_WIDTH-1:0] ds_ctr;

   // Plain decimation, one strobe every downsample+1 cycles
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ds_ctr        <= '0;
         sample_strobe <= 1'b0;
      end else if (capture_go) begin
         // Realign to the trigger
         ds_ctr        <= '0;
         sample_strobe <= 1'b0;
      end else if (ds_ctr == ctrl.downsample) begin
         ds_ctr        <= '0;
         sample_strobe <= 1'b1;
      end else begin
         ds_ctr        <= ds_ctr + 1'b1;
         sample_strobe <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== capture/la_capture.sv ====
`default_nettype none
`include "la_cfg.svh"

module la_capture (
   input  wire                     observer_clk,
   input  wire                     reset,
   input  wire                     capture_go,
   input  wire                     sample_strobe,
   input  wire [`LA_CHANNELS-1:0]  io_group,
   input  wire [`LA_CHANNELS-1:0]  userio_group,
   input  wire [`LA_CHANNELS-1:0]  debug_group,
   input  wire [`LA_CHANNELS-1:0]  trace_group,
   la_ctrl_if.capture              ctrl
);

   localparam int CNT_W = $clog2(`LA_DEPTH);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`LA_DEPTH - 1);

   // Channel 0 reads 1, channel 1 reads 0 and so on
   localparam logic [`LA_CHANNELS-1:0] TEST_PATTERN =
      `LA_CHANNELS'({((`LA_CHANNELS + 1) / 2){2'b01}});

   localparam logic [3:0] NUM_CHANNELS = 4'(`LA_CHANNELS);

   logic [`LA_CHANNELS-1:0] probe_src;
   logic [`LA_DEPTH-1:0]    chan_q [`LA_CHANNELS];
   logic [CNT_W-1:0]        capture_count;

   // Probe sources registered once per cycle
   always_ff @(posedge observer_clk) begin
      case (ctrl.capture_group)
         la_pkg::GRP_IO:     probe_src <= io_group;
         la_pkg::GRP_USERIO: probe_src <= userio_group;
         la_pkg::GRP_DEBUG:  probe_src <= debug_group;
         la_pkg::GRP_TRACE:  probe_src <= trace_group;
         default:            probe_src <= TEST_PATTERN;
      endcase
   end

   // Shift registers fill from the top, oldest sample ends at bit 0
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capture_count  <= '0;
         ctrl.capturing <= 1'b0;
         for (int n = 0; n < `LA_CHANNELS; n++) begin
            chan_q[n] <= '0;
         end
      end else if (capture_go) begin
         // Restart, even in the middle of a capture
         capture_count  <= '0;
         ctrl.capturing <= 1'b1;
         for (int n = 0; n < `LA_CHANNELS; n++) begin
            chan_q[n] <= {probe_src[n], {(`LA_DEPTH - 1){1'b0}}};
         end
      end else if (ctrl.capturing && sample_strobe) begin
         for (int n = 0; n < `LA_CHANNELS; n++) begin
            chan_q[n] <= {probe_src[n], chan_q[n][`LA_DEPTH-1:1]};
         end
         if (capture_count < CNT_LAST) begin
            capture_count <= capture_count + 1'b1;
         end else begin
            ctrl.capturing <= 1'b0;  // Buffer full
         end
      end
   end

   // Readback of the selected channel
   always_ff @(posedge observer_clk) begin
      if (ctrl.read_select < NUM_CHANNELS) begin
         ctrl.channel_data <= chan_q[ctrl.read_select];
      end else begin
         ctrl.channel_data <= {`LA_DEPTH_BYTES{`LA_BAD_SELECT_BYTE}};
      end
   end

endmodule

`default_nettype wire

// ==== source/la_top.sv ====
`default_nettype none
`include "la_cfg.svh"

module la_top (
   input  wire                          observer_clk,
   input  wire                          reset,
   input  wire [7:0]                    reg_address,
   input  wire [`LA_BYTECNT_WIDTH-1:0]  reg_bytecnt,
   input  wire [7:0]                    reg_datai,
   input  wire                          reg_read,
   input  wire                          reg_write,
   output logic [7:0]                   reg_datao,
   input  wire                          glitch_go,
   input  wire                          capture_active,
   input  wire [`LA_CHANNELS-1:0]       io_group,
   input  wire [`LA_CHANNELS-1:0]       userio_group,
   input  wire [`LA_CHANNELS-1:0]       debug_group,
   input  wire [`LA_CHANNELS-1:0]       trace_group
);

   logic capture_go;     // Trigger pulse
   logic sample_strobe;  // Decimated sample enable

   la_ctrl_if ctrl ();

   la_regs u_regs (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .reg_bytecnt  (reg_bytecnt),
      .reg_datai    (reg_datai),
      .reg_read     (reg_read),
      .reg_write    (reg_write),
      .reg_datao    (reg_datao),
      .ctrl         (ctrl.regs)
   );

   la_trigger u_trigger (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .glitch_go      (glitch_go),
      .capture_active (capture_active),
      .hs1            (io_group[4]),     // hs1 sits in the IO group
      .debug0         (debug_group[0]),
      .ctrl           (ctrl.trigger),
      .capture_go     (capture_go)
   );

   la_sample_timer u_sample_timer (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_go    (capture_go),
      .ctrl          (ctrl.timer),
      .sample_strobe (sample_strobe)
   );

   la_capture u_capture (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_go    (capture_go),
      .sample_strobe (sample_strobe),
      .io_group      (io_group),
      .userio_group  (userio_group),
      .debug_group   (debug_group),
      .trace_group   (trace_group),
      .ctrl          (ctrl.capture)
   );

endmodule

`default_nettype wire

// ==== tests/la_props.sv ====
`default_nettype none

module la_props (
   input wire       observer_clk,
   input wire       reset,
   input wire       capture_go,
   input wire       sample_strobe,
   input wire       reg_read,
   input wire [7:0] reg_datao
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;  // Read by the testbench at the end

   // Edge detector gives a single cycle pulse
   go_single: assert property (@(posedge observer_clk) disable iff (reset)
                               capture_go |=> !capture_go)
      else begin
         fail_count++;
         $error("capture_go high for two cycles");
      end

   // Read mux idles at zero
   datao_idle: assert property (@(posedge observer_clk) disable iff (reset)
                                !reg_read |-> reg_datao == 8'h00)
      else begin
         fail_count++;
         $error("reg_datao nonzero without reg_read");
      end

   strobe_after_go: assert property (@(posedge observer_clk) disable iff (reset)
                                     capture_go |=> !sample_strobe)
      else begin
         fail_count++;
         $error("sample_strobe high right after capture_go");
      end

endmodule

bind la_top la_props u_props (
   .observer_clk  (observer_clk),
   .reset         (reset),
   .capture_go    (capture_go),
   .sample_strobe (sample_strobe),
   .reg_read      (reg_read),
   .reg_datao     (reg_datao)
);

`default_nettype wire

// ==== tests/la_tb.sv ====
`default_nettype none
`include "la_cfg.svh"

module la_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic                          observer_clk;
   logic                          reset;
   logic [7:0]                    reg_address;
   logic [`LA_BYTECNT_WIDTH-1:0]  reg_bytecnt;
   logic [7:0]                    reg_datai;
   logic                          reg_read;
   logic                          reg_write;
   logic [7:0]                    reg_datao;
   logic                          glitch_go;
   logic                          capture_active;
   logic [`LA_CHANNELS-1:0]       io_group;
   logic [`LA_CHANNELS-1:0]       userio_group;
   logic [`LA_CHANNELS-1:0]       debug_group;
   logic [`LA_CHANNELS-1:0]       trace_group;

   logic [31:0] lfsr_state = 32'h9168_2741;
   logic [7:0]  rdata;
   logic [15:0] ds_value;
   logic [2:0]  grp;
   logic [7:0]  bad_addr;
   logic        seen;
   int          cycles;
   int          ds_small;
   int          lo;
   int          hi;

   la_top UUT (.*);

   always #50 observer_clk = ~observer_clk;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], lfsr_bit()};
      end
      return value;
   endfunction

   // Reference model, held group values give a constant channel
   function automatic logic model_bit(input logic [2:0] group, input int n);
      case (group)
         3'd0:    return io_group[n];
         3'd1:    return userio_group[n];
         3'd2:    return debug_group[n];
         3'd3:    return trace_group[n];
         default: return (n % 2) == 0;  // Test pattern
      endcase
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h",
                             name, expected, actual));
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input int bytecnt, input logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= `LA_BYTECNT_WIDTH'(bytecnt);
      reg_datai   <= data;
      reg_read    <= 1'b0;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   // Data sampled mid cycle, the read mux is combinational
   task automatic read_reg(input logic [7:0] addr, input int bytecnt, output logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= `LA_BYTECNT_WIDTH'(bytecnt);
      reg_write   <= 1'b0;
      reg_read    <= 1'b1;
      @(negedge observer_clk);
      data = reg_datao;
   endtask

   // Holds a STATUS read and counts cycles until capturing equals level
   task automatic poll_capturing(input logic level, input int limit,
                                 output int n_cycles, output logic found);
      @(posedge observer_clk);
      reg_address <= la_pkg::STATUS;
      reg_bytecnt <= '0;
      reg_write   <= 1'b0;
      reg_read    <= 1'b1;
      found = 1'b0;
      n_cycles = 0;
      while (!found && n_cycles < limit) begin
         @(negedge observer_clk);
         n_cycles++;
         found = (reg_datao[0] == level);
      end
   endtask

   task automatic wait_capture_end(input int limit);
      int   n;
      logic found;
      poll_capturing(1'b0, limit, n, found);
      if (!found) abort_run("Timeout waiting for capturing to fall");
   endtask

   task automatic wait_capture_done();
      int   n;
      logic found;
      poll_capturing(1'b1, 20, n, found);
      if (!found) abort_run("Capture did not start after the trigger");
      wait_capture_end(2000);
   endtask

   task automatic set_trigger_input(input int src, input logic level);
      @(posedge observer_clk);
      case (src)
         1:       capture_active <= level;
         2:       io_group[4] <= level;      // hs1
         3:       debug_group[0] <= level;
         default: glitch_go <= level;
      endcase
   endtask

   initial begin
      observer_clk   = 1'b0;
      reset          = 1'b1;
      reg_address    = '0;
      reg_bytecnt    = '0;
      reg_datai      = '0;
      reg_read       = 1'b0;
      reg_write      = 1'b0;
      glitch_go      = 1'b0;
      capture_active = 1'b0;
      io_group       = '0;
      userio_group   = '0;
      debug_group    = '0;
      trace_group    = '0;
      repeat (3) @(posedge observer_clk);
      reset <= 1'b0;

      // 1. Reset values and register readback
      read_reg(la_pkg::TRIGGER_SOURCE, 0, rdata);
      check("reset trigger source", 0, 32'(rdata));
      read_reg(la_pkg::CAPTURE_GROUP, 0, rdata);
      check("reset capture group", 0, 32'(rdata));
      read_reg(la_pkg::STATUS, 0, rdata);
      check("reset status", 0, 32'(rdata));
      read_reg(la_pkg::CAPTURE_DEPTH, 0, rdata);
      check("capture depth byte 0", `LA_DEPTH % 256, 32'(rdata));
      read_reg(la_pkg::CAPTURE_DEPTH, 1, rdata);
      check("capture depth byte 1", `LA_DEPTH / 256, 32'(rdata));
      ds_value = 16'(rand_bits(16));
      write_reg(la_pkg::DOWNSAMPLE, 0, ds_value[7:0]);
      write_reg(la_pkg::DOWNSAMPLE, 1, ds_value[15:8]);
      read_reg(la_pkg::DOWNSAMPLE, 0, rdata);
      check("downsample byte 0", 32'(ds_value[7:0]), 32'(rdata));
      read_reg(la_pkg::DOWNSAMPLE, 1, rdata);
      check("downsample byte 1", 32'(ds_value[15:8]), 32'(rdata));
      grp = 3'(rand_bits(3));
      write_reg(la_pkg::CAPTURE_GROUP, 0, {5'b0, grp});
      read_reg(la_pkg::CAPTURE_GROUP, 0, rdata);
      check("capture group readback", 32'(grp), 32'(rdata));
      grp = 3'(rand_bits(3));
      write_reg(la_pkg::TRIGGER_SOURCE, 0, {5'b0, grp});
      read_reg(la_pkg::TRIGGER_SOURCE, 0, rdata);
      check("trigger source readback", 32'(grp), 32'(rdata));

      // 2. Manual capture of held random groups
      write_reg(la_pkg::TRIGGER_SOURCE, 0, 8'd7);
      write_reg(la_pkg::DOWNSAMPLE, 0, 8'd0);
      write_reg(la_pkg::DOWNSAMPLE, 1, 8'd0);
      @(posedge observer_clk);
      io_group     <= `LA_CHANNELS'(rand_bits(`LA_CHANNELS));
      userio_group <= `LA_CHANNELS'(rand_bits(`LA_CHANNELS));
      debug_group  <= `LA_CHANNELS'(rand_bits(`LA_CHANNELS));
      trace_group  <= `LA_CHANNELS'(rand_bits(`LA_CHANNELS));
      grp = 3'(rand_bits(3) % 5);
      write_reg(la_pkg::CAPTURE_GROUP, 0, {5'b0, grp});
      write_reg(la_pkg::MANUAL_CAPTURE, 0, 8'd1);
      write_reg(la_pkg::MANUAL_CAPTURE, 0, 8'd0);
      wait_capture_done();
      for (int n = 0; n < `LA_CHANNELS; n++) begin
         write_reg(la_pkg::READ_SELECT, 0, 8'(n));
         for (int b = 0; b < `LA_DEPTH_BYTES; b++) begin
            read_reg(la_pkg::READ_SELECT, b, rdata);
            check($sformatf("group %0d channel %0d byte %0d", grp, n, b),
                  model_bit(grp, n) ? 32'hFF : 32'h00, 32'(rdata));
         end
      end

      // 3. Each trigger source, then no source
      @(posedge observer_clk);
      io_group     <= '0;
      userio_group <= '0;
      debug_group  <= '0;
      trace_group  <= '0;
      for (int src = 0; src < 4; src++) begin
         write_reg(la_pkg::TRIGGER_SOURCE, 0, 8'(src));
         set_trigger_input(src, 1'b1);
         poll_capturing(1'b1, 10, cycles, seen);
         check($sformatf("trigger source %0d starts capture", src), 1, 32'(seen));
         set_trigger_input(src, 1'b0);
         wait_capture_end(2000);
      end
      write_reg(la_pkg::TRIGGER_SOURCE, 0, 8'd7);
      set_trigger_input(0, 1'b1);
      poll_capturing(1'b1, 20, cycles, seen);
      check("trigger source 7 gives no capture", 0, 32'(seen));
      set_trigger_input(0, 1'b0);

      // 4. Capture length against downsample
      ds_small = int'(rand_bits(2));
      write_reg(la_pkg::DOWNSAMPLE, 0, 8'(ds_small));
      lo = `LA_DEPTH * (ds_small + 1) - 2;
      hi = `LA_DEPTH * (ds_small + 1) + 4;
      write_reg(la_pkg::MANUAL_CAPTURE, 0, 8'd1);
      poll_capturing(1'b1, 20, cycles, seen);
      check("manual capture starts", 1, 32'(seen));
      poll_capturing(1'b0, `LA_DEPTH * 4 + 50, cycles, seen);
      check("capture ends", 1, 32'(seen));
      check($sformatf("capture length %0d within %0d to %0d", cycles, lo, hi),
            1, 32'(cycles >= lo && cycles <= hi));
      write_reg(la_pkg::MANUAL_CAPTURE, 0, 8'd0);

      // 5. Bad read select and unknown address
      for (int sel = `LA_CHANNELS; sel < 16; sel++) begin
         write_reg(la_pkg::READ_SELECT, 0, 8'(sel));
         for (int b = 0; b < `LA_DEPTH_BYTES; b++) begin
            read_reg(la_pkg::READ_SELECT, b, rdata);
            check($sformatf("select %0d byte %0d", sel, b),
                  32'(`LA_BAD_SELECT_BYTE), 32'(rdata));
         end
      end
      bad_addr = 8'(7 + rand_bits(8) % 249);
      read_reg(bad_addr, 0, rdata);
      check($sformatf("unknown address %0h", bad_addr), 0, 32'(rdata));

      if (UUT.u_props.fail_count != 0) begin
         abort_run("Assertion failures were reported");
      end else begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/la_pkg.sv
common/la_ctrl_if.sv
source/la_regs.sv
trigger/la_trigger.sv
source/la_sample_timer.sv
capture/la_capture.sv
source/la_top.sv
tests/la_props.sv
tests/la_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the logic analyzer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
      --top-module la_tb -f vlog.f -o la_sim; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/la_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
   exit 0
fi
echo "Pass message not found"
exit 1
